/* spanPainter.f */
gfxPkg.sv
busPkg.sv
commandQueue.sv
spanRasterizer.sv
frameStore.sv
painterTop.sv
painterTb.sv

/* runSim.sh */
#!/bin/sh
# Compile and run the span painter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module painterTb -f spanPainter.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VpainterTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* painterTb.sv */
`default_nettype none

module painterTb;

	localparam int queueDepth = 8; // fifoDepthLog2 of 3
	localparam int commandCount = 48; // Upper bound over all tests
	localparam int spanClocks = gfxPkg::screenWidth + 14; // Paint, decode and bus turns
	localparam int scanClocks = 2 * gfxPkg::bankSize; // One full bank compare
	localparam int bankChecks = 6;
	// Clocks times period times a margin of two
	localparam int watchdogTime = 20 * (16 + commandCount * spanClocks + bankChecks * scanClocks);

	logic clk = 1'b0;
	logic reset;
	busPkg::wbRequest wbIn;
	busPkg::wbResponse wbOut;
	logic frameTick;
	gfxPkg::pixelAddr scanAddr;
	gfxPkg::pixelColor scanColor;

	// Reference model of both banks
	bit [2:0] modelColor [2][gfxPkg::bankSize];
	bit modelKnown [2][gfxPkg::bankSize]; // Never painted means unknown
	bit modelFront;
	string testName;
	integer seed;

	painterTop #(
		.fifoDepthLog2(3)
	) DUT (
		.clk(clk),
		.reset(reset),
		.wbIn(wbIn),
		.wbOut(wbOut),
		.frameTick(frameTick),
		.scanAddr(scanAddr),
		.scanColor(scanColor)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Failure paths
	//////////////////////////////////////////////////////////////////////
	task automatic flagMismatch(input string name, input int expected, input int actual);
		$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic abortRun(input string what);
		$display("Error during %s: %s", testName, what);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	initial
	begin
		#(watchdogTime);
		$display("Timeout: run still busy after %0d time units", watchdogTime);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end

	// Bus protocol checked on every clock
	ackNeedsRequest: assert property (@(posedge clk) disable iff (reset)
		wbOut.ack |-> (wbIn.cyc && wbIn.stb))
		else abortRun("ack was raised without cyc and stb");

	ackSingleClock: assert property (@(posedge clk) disable iff (reset)
		wbOut.ack |=> !wbOut.ack)
		else abortRun("ack stayed high for more than one clock");

	//////////////////////////////////////////////////////////////////////
	// Wishbone master
	//////////////////////////////////////////////////////////////////////
	task automatic transferWord(input logic we, input busPkg::wbAddr adr,
		input busPkg::wbData wdata, output busPkg::wbData rdata);
		@(negedge clk);
		wbIn.cyc = 1'b1;
		wbIn.stb = 1'b1;
		wbIn.we = we;
		wbIn.adr = adr;
		wbIn.dat = wdata;
		@(negedge clk);
		while (!wbOut.ack)
			@(negedge clk); // Full queue holds ack back
		rdata = wbOut.dat;
		@(negedge clk); // Request held through the ack clock
		wbIn.cyc = 1'b0;
		wbIn.stb = 1'b0;
		wbIn.we = 1'b0;
	endtask

	task automatic writeRegister(input busPkg::wbAddr adr, input busPkg::wbData data);
		busPkg::wbData ignored;
		transferWord(1'b1, adr, data, ignored);
	endtask

	task automatic readRegister(input busPkg::wbAddr adr, output busPkg::wbData data);
		transferWord(1'b0, adr, '0, data);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Span model
	//////////////////////////////////////////////////////////////////////
	function automatic busPkg::wbData makeSpan(input int color, input int row,
		input int left, input int right);
		return {6'b0, 3'(color), 7'(row), 8'(left), 8'(right)};
	endfunction

	// Paints the model's back bank by the span rules
	function automatic void applySpan(input busPkg::wbData word);
		int color;
		int row;
		int left;
		int right;
		int lastCol;
		bit backIdx;
		if (word == gfxPkg::swapCode)
			return;
		color = int'(word[25:23]);
		row = int'(word[22:16]);
		left = int'(word[15:8]);
		right = int'(word[7:0]);
		if (row >= gfxPkg::screenHeight || left >= gfxPkg::screenWidth)
			return; // Off-screen start is dropped
		lastCol = (right > gfxPkg::screenWidth - 1) ? gfxPkg::screenWidth - 1 : right;
		if (lastCol <= left)
			lastCol = left; // Left column only
		backIdx = ~modelFront;
		for (int c = left; c <= lastCol; c++)
		begin
			modelColor[backIdx][15'(row * gfxPkg::screenWidth + c)] = 3'(color);
			modelKnown[backIdx][15'(row * gfxPkg::screenWidth + c)] = 1'b1;
		end
	endfunction

	task automatic queueCommand(input busPkg::wbData word);
		writeRegister(busPkg::regCommand, word);
		applySpan(word);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Frame store access
	//////////////////////////////////////////////////////////////////////
	task automatic readPixel(input int addr, output gfxPkg::pixelColor color);
		@(negedge clk);
		scanAddr = 15'(addr);
		@(negedge clk); // Registered read
		color = scanColor;
	endtask

	task automatic pulseFrameTick();
		@(negedge clk);
		frameTick = 1'b1;
		@(negedge clk);
		frameTick = 1'b0;
	endtask

	// Every known pixel of the front bank against the model
	task automatic compareFront();
		gfxPkg::pixelColor seen;
		for (int a = 0; a < gfxPkg::bankSize; a++)
		begin
			if (modelKnown[modelFront][15'(a)])
			begin
				readPixel(a, seen);
				pixelMatch: assert (seen == modelColor[modelFront][15'(a)])
					else flagMismatch($sformatf("%s pixel %0d", testName, a),
						int'(modelColor[modelFront][15'(a)]), int'(seen));
			end
		end
	endtask

	task automatic swapBuffers();
		busPkg::wbData status;
		bit oldFront;
		oldFront = modelFront;
		queueCommand(gfxPkg::swapCode);
		readRegister(busPkg::regStatus, status);
		// Ticks only count once the painter reaches the swap
		while (status[busPkg::statusFrontBit] == oldFront)
		begin
			pulseFrameTick();
			readRegister(busPkg::regStatus, status);
		end
		modelFront = ~modelFront;
		swapCleared: assert (status[busPkg::statusSwapBit] == 1'b0)
			else flagMismatch({testName, " swap pending"}, 0,
				int'(status[busPkg::statusSwapBit]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		busPkg::wbData status;
		int color;
		int row;
		int left;
		int right;
		seed = 32'h984f9ba7;
		reset = 1'b1;
		wbIn = '0;
		frameTick = 1'b0;
		scanAddr = '0;
		modelFront = 1'b0;
		testName = "reset";
		repeat (16) @(negedge clk);
		reset = 1'b0;

		testName = "idle status";
		readRegister(busPkg::regStatus, status);
		idleFill: assert (status[15:0] == 16'd0)
			else flagMismatch(testName, 0, int'(status[15:0]));
		idleFront: assert (status[busPkg::statusFrontBit] == 1'b0)
			else flagMismatch(testName, 0, int'(status[busPkg::statusFrontBit]));
		readRegister(busPkg::wbAddr'(2), status); // Unmapped reads as zero
		unmappedZero: assert (status == '0)
			else flagMismatch("unmapped read", 0, int'(status));

		testName = "single span";
		queueCommand(makeSpan(1, 60, 0, 159)); // Background for the row
		queueCommand(makeSpan(5, 60, 40, 90));
		swapBuffers();
		compareFront();

		testName = "edge rules";
		for (int r = 20; r <= 24; r++)
			queueCommand(makeSpan(7, r, 0, 159));
		queueCommand(makeSpan(2, 20, 30, 30)); // Single column
		queueCommand(makeSpan(3, 21, 50, 10)); // Reversed span paints left only
		queueCommand(makeSpan(4, 22, 150, 200)); // Clipped at 159
		queueCommand(makeSpan(5, 120, 0, 159)); // Row off screen
		queueCommand(makeSpan(6, 23, 170, 180)); // Start column off screen
		swapBuffers();
		compareFront();

		testName = "double buffering";
		for (int r = 40; r < 44; r++)
			queueCommand(makeSpan(r - 39, r, 0, 159)); // Frame A
		swapBuffers();
		compareFront();
		for (int r = 40; r < 44; r++)
			queueCommand(makeSpan(r - 36, r, 20, 120)); // Frame B before its swap
		compareFront(); // Still frame A
		readRegister(busPkg::regStatus, status);
		noPendingYet: assert (status[busPkg::statusSwapBit] == 1'b0)
			else flagMismatch(testName, 0, int'(status[busPkg::statusSwapBit]));
		queueCommand(gfxPkg::swapCode);
		do
		begin
			readRegister(busPkg::regStatus, status);
			frontHeld: assert (status[busPkg::statusFrontBit] == modelFront)
				else flagMismatch(testName, int'(modelFront),
					int'(status[busPkg::statusFrontBit]));
		end
		while (status[busPkg::statusSwapBit] == 1'b0);
		pulseFrameTick();
		readRegister(busPkg::regStatus, status);
		frontToggled: assert (status[busPkg::statusFrontBit] == ~modelFront)
			else flagMismatch(testName, int'(!modelFront),
				int'(status[busPkg::statusFrontBit]));
		pendingCleared: assert (status[busPkg::statusSwapBit] == 1'b0)
			else flagMismatch(testName, 0, int'(status[busPkg::statusSwapBit]));
		modelFront = ~modelFront;
		compareFront();

		testName = "back-pressure";
		for (int n = 0; n < 20; n++)
		begin
			// Narrow row band so spans overlap and a few rows drop
			color = $random(seed) & 7;
			row = 100 + ($random(seed) & 32'h7fff_ffff) % 24;
			left = ($random(seed) & 32'h7fff_ffff) % 168;
			right = ($random(seed) & 32'h7fff_ffff) % 200;
			queueCommand(makeSpan(color, row, left, right));
			readRegister(busPkg::regStatus, status);
			fillBound: assert (status[15:0] <= 16'(queueDepth))
				else flagMismatch(testName, queueDepth, int'(status[15:0]));
		end
		swapBuffers();
		compareFront();

		testName = "bus protocol";
		readRegister(busPkg::regStatus, status);
		finalFill: assert (status[15:0] == 16'd0)
			else flagMismatch(testName, 0, int'(status[15:0]));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* painterTop.sv */
`default_nettype none

module painterTop #(
	parameter int fifoDepthLog2 = 4 // Queue holds 2**fifoDepthLog2 words
) (
	input wire logic clk,
	input wire logic reset,
	input wire busPkg::wbRequest wbIn, // Host bus
	output busPkg::wbResponse wbOut,
	input wire logic frameTick,
	input wire gfxPkg::pixelAddr scanAddr, // Display read side
	output gfxPkg::pixelColor scanColor
);

	////////////////////////////////////////////////////////////////////////
	// Internal links
	////////////////////////////////////////////////////////////////////////
	busPkg::wbData cmdWord; // Queue head
	logic cmdValid;
	logic cmdTake;
	gfxPkg::pixelWrite pixelBus; // Rasterizer to frame store
	logic swapRequest;
	logic swapDone;
	logic frontBank; // Status flags back to the bus
	logic swapPending;

	commandQueue #(
		.fifoDepthLog2(fifoDepthLog2)
	) queue (
		.clk(clk),
		.reset(reset),
		.wbIn(wbIn),
		.wbOut(wbOut),
		.cmdWord(cmdWord),
		.cmdValid(cmdValid),
		.cmdTake(cmdTake),
		.frontBank(frontBank),
		.swapPending(swapPending)
	);

	spanRasterizer rasterizer (
		.clk(clk),
		.reset(reset),
		.cmdWord(cmdWord),
		.cmdValid(cmdValid),
		.cmdTake(cmdTake),
		.pixelOut(pixelBus),
		.swapRequest(swapRequest),
		.swapDone(swapDone)
	);

	frameStore store (
		.clk(clk),
		.reset(reset),
		.pixelIn(pixelBus),
		.swapRequest(swapRequest),
		.frameTick(frameTick),
		.scanAddr(scanAddr),
		.scanColor(scanColor),
		.swapDone(swapDone),
		.frontBank(frontBank),
		.swapPending(swapPending)
	);

endmodule

`default_nettype wire

/* frameStore.sv */
`default_nettype none

module frameStore (
	input wire logic clk,
	input wire logic reset,
	input wire gfxPkg::pixelWrite pixelIn, // Lands in the back bank
	input wire logic swapRequest,
	input wire logic frameTick, // End of displayed frame
	input wire gfxPkg::pixelAddr scanAddr,
	output gfxPkg::pixelColor scanColor, // One clock after scanAddr
	output logic swapDone,
	output logic frontBank,
	output logic swapPending
);

	//////////////////////////////////////////////////////////////////////
	// Bank exchange
	//////////////////////////////////////////////////////////////////////
	logic swapWanted; // Pending flag or a fresh request

	// Request stays high during the swapDone clock, so mask it there
	assign swapWanted = swapPending | (swapRequest & ~swapDone);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			frontBank <= 1'b0;
			swapPending <= 1'b0;
			swapDone <= 1'b0;
		end
		else
		begin
			swapDone <= 1'b0;
			if (swapWanted && frameTick)
			begin
				frontBank <= ~frontBank; // Exchange front and back
				swapPending <= 1'b0;
				swapDone <= 1'b1; // Seen with the new front bank
			end
			else
				swapPending <= swapWanted; // Wait for the next tick
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pixel banks
	//////////////////////////////////////////////////////////////////////
	gfxPkg::pixelColor bankMem [2][gfxPkg::bankSize];

	logic backBank;
	assign backBank = ~frontBank;

	// Painter side, back bank only
	always_ff @(posedge clk)
	begin
		if (pixelIn.strobe)
			bankMem[backBank][pixelIn.addr] <= pixelIn.color;
	end

	// Scan-out side, front bank as sampled with the address
	always_ff @(posedge clk)
	begin
		scanColor <= bankMem[frontBank][scanAddr];
	end

endmodule

`default_nettype wire

/* spanRasterizer.sv */
`default_nettype none

module spanRasterizer (
	input wire logic clk,
	input wire logic reset,
	input wire busPkg::wbData cmdWord, // Queue head
	input wire logic cmdValid,
	output logic cmdTake, // One clock pop strobe
	output gfxPkg::pixelWrite pixelOut, // Into the back bank
	output logic swapRequest, // Held until swapDone
	input wire logic swapDone
);

	typedef enum logic [1:0]
	{
		stIdle,
		stDecode,
		stPaint,
		stWaitSwap
	} painterState;

	painterState state;

	//////////////////////////////////////////////////////////////////////
	// Command decode, all combinational off the queue head
	//////////////////////////////////////////////////////////////////////
	gfxPkg::spanCommand span;
	gfxPkg::colIndex rightClip; // Right edge limited to the screen
	gfxPkg::colIndex endCol;
	gfxPkg::pixelAddr rowBase; // row * 160
	gfxPkg::pixelAddr spanStart;
	gfxPkg::pixelAddr spanEnd;
	logic isSwap;
	logic spanValid;

	assign span = gfxPkg::spanCommand'(cmdWord[25:0]); // Top six bits ignored
	assign isSwap = (cmdWord == gfxPkg::swapCode);

	// Off-screen row or start column drops the span
	assign spanValid = (span.row < gfxPkg::rowIndex'(gfxPkg::screenHeight))
		&& (span.left < gfxPkg::colIndex'(gfxPkg::screenWidth));

	always_comb
	begin
		if (span.right > gfxPkg::colIndex'(gfxPkg::screenWidth - 1))
			rightClip = gfxPkg::colIndex'(gfxPkg::screenWidth - 1);
		else
			rightClip = span.right;

		// Empty or reversed span paints just the left column
		if (rightClip <= span.left)
			endCol = span.left;
		else
			endCol = rightClip;
	end

	// Shift-and-add, 128 + 32 = 160
	assign rowBase = (gfxPkg::pixelAddr'(span.row) << 7)
		+ (gfxPkg::pixelAddr'(span.row) << 5);
	assign spanStart = rowBase + gfxPkg::pixelAddr'(span.left);
	assign spanEnd = rowBase + gfxPkg::pixelAddr'(endCol);

	//////////////////////////////////////////////////////////////////////
	// Span walker
	//////////////////////////////////////////////////////////////////////
	gfxPkg::pixelAddr curAddr; // Next pixel to write
	gfxPkg::pixelAddr endAddr; // Last pixel, inclusive
	gfxPkg::pixelColor spanColor;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
			cmdTake <= 1'b0;
			swapRequest <= 1'b0;
			pixelOut <= '0;
			curAddr <= '0;
			endAddr <= '0;
			spanColor <= '0;
		end
		else
		begin
			cmdTake <= 1'b0; // Pulse only
			pixelOut.strobe <= 1'b0;

			case (state)
				stIdle:
				begin
					if (cmdValid)
					begin
						cmdTake <= 1'b1; // Pops the head next clock
						state <= stDecode;
					end
				end

				stDecode:
				begin
					// Head still valid while cmdTake is high
					if (isSwap)
					begin
						swapRequest <= 1'b1;
						state <= stWaitSwap;
					end
					else if (spanValid)
					begin
						curAddr <= spanStart;
						endAddr <= spanEnd;
						spanColor <= span.color;
						state <= stPaint;
					end
					else
						state <= stIdle; // Dropped, nothing painted
				end

				stPaint:
				begin
					pixelOut.strobe <= 1'b1;
					pixelOut.addr <= curAddr;
					pixelOut.color <= spanColor;
					curAddr <= curAddr + 1'b1;
					if (curAddr == endAddr)
						state <= stIdle; // Last pixel goes out now
				end

				stWaitSwap:
				begin
					if (swapDone)
					begin
						swapRequest <= 1'b0;
						state <= stIdle;
					end
				end

				default:
					state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* commandQueue.sv */
`default_nettype none

module commandQueue #(
	parameter int fifoDepthLog2 = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire busPkg::wbRequest wbIn,
	output busPkg::wbResponse wbOut,
	output busPkg::wbData cmdWord, // Head of queue, fall-through
	output logic cmdValid,
	input wire logic cmdTake, // Pop the head
	input wire logic frontBank,
	input wire logic swapPending
);

	localparam int fifoDepth = 1 << fifoDepthLog2;

	//////////////////////////////////////////////////////////////////////
	// Command storage
	//////////////////////////////////////////////////////////////////////
	busPkg::wbData fifoMem [fifoDepth];
	logic [fifoDepthLog2-1:0] readPtr;
	logic [fifoDepthLog2-1:0] writePtr; // Both wrap at the depth
	logic [fifoDepthLog2:0] fillCount; // 0 to fifoDepth inclusive

	logic queueFull;
	logic pushWord;
	logic popWord;

	assign queueFull = (fillCount == (fifoDepthLog2 + 1)'(fifoDepth));
	assign cmdValid = (fillCount != '0);
	assign cmdWord = fifoMem[readPtr]; // First word falls through
	assign popWord = cmdTake & cmdValid;

	//////////////////////////////////////////////////////////////////////
	// Wishbone slave
	//////////////////////////////////////////////////////////////////////
	logic busActive; // Transfer seen and not yet answered
	logic cmdWrite;
	logic canAck;
	busPkg::wbData statusWord;

	assign busActive = wbIn.cyc & wbIn.stb & ~wbOut.ack;
	assign cmdWrite = wbIn.we & (wbIn.adr == busPkg::regCommand);
	assign canAck = ~cmdWrite | ~queueFull; // Full queue stalls the host

	// Master still holds the request during the ack clock
	assign pushWord = wbOut.ack & wbIn.cyc & wbIn.stb & cmdWrite;

	always_comb
	begin
		statusWord = '0;
		statusWord[15:0] = 16'(fillCount);
		statusWord[busPkg::statusFrontBit] = frontBank;
		statusWord[busPkg::statusSwapBit] = swapPending;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wbOut <= '0;
		end
		else
		begin
			wbOut.ack <= busActive & canAck; // Single clock, then stb falls
			if (busActive && !wbIn.we && wbIn.adr == busPkg::regStatus)
				wbOut.dat <= statusWord;
			else
				wbOut.dat <= '0; // Writes and unmapped reads
		end
	end

	// Pointers and fill level
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			readPtr <= '0;
			writePtr <= '0;
			fillCount <= '0;
		end
		else
		begin
			if (pushWord)
				writePtr <= writePtr + 1'b1;
			if (popWord)
				readPtr <= readPtr + 1'b1;
			case ({pushWord, popWord})
				2'b10: fillCount <= fillCount + 1'b1;
				2'b01: fillCount <= fillCount - 1'b1;
				default: fillCount <= fillCount; // Both or neither
			endcase
		end
	end

	// Word storage, no reset
	always_ff @(posedge clk)
	begin
		if (pushWord)
			fifoMem[writePtr] <= wbIn.dat;
	end

endmodule

`default_nettype wire

/* busPkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Wishbone classic structs and slave register map
////////////////////////////////////////////////////////////////////////
package busPkg;

	typedef logic [1:0] wbAddr; // Word address
	typedef logic [31:0] wbData;

	// Master to slave
	typedef struct packed
	{
		logic cyc;
		logic stb;
		logic we;
		wbAddr adr;
		wbData dat; // Write data
	} wbRequest;

	// Slave to master
	typedef struct packed
	{
		logic ack; // One clock per transfer
		wbData dat; // Read data
	} wbResponse;

	// Register map
	localparam wbAddr regCommand = 2'd0; // Write only, span or swap
	localparam wbAddr regStatus = 2'd1; // Read only
	localparam int statusFrontBit = 16; // Front bank index
	localparam int statusSwapBit = 17; // Swap still waiting for a frame tick

endpackage

`default_nettype wire

/* gfxPkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Raster geometry, colors and span traffic
////////////////////////////////////////////////////////////////////////
package gfxPkg;

	// Visible area
	localparam int screenWidth = 160;
	localparam int screenHeight = 120;
	localparam int bankSize = screenWidth * screenHeight; // Pixels per bank

	typedef logic [2:0] pixelColor; // One bit per gun
	typedef logic [6:0] rowIndex; // 0 to 119
	typedef logic [7:0] colIndex; // 0 to 159
	typedef logic [14:0] pixelAddr; // row * 160 + col

	// Whole command word that asks for a front/back exchange
	localparam logic [31:0] swapCode = 32'hFFFF_FFFF;

	// Low 26 bits of a command word, top bits first
	typedef struct packed
	{
		pixelColor color;
		rowIndex row;
		colIndex left;
		colIndex right; // Inclusive end column
	} spanCommand;

	// One pixel per clock into the back bank
	typedef struct packed
	{
		logic strobe; // Write this clock
		pixelAddr addr;
		pixelColor color;
	} pixelWrite;

endpackage

`default_nettype wire
